// ==== bench/cpu_vectors.txt ====
# T name | I addr instr | D addr word | W reg value | S addr value
# All numbers hex, W and S in the order the pipeline must produce them
T alu_chain
I 00 28400005
I 01 28820003
I 02 00c22000
I 03 01061004
I 04 01480210
I 05 018a200c
I 06 01cc3008
I 07 2a01fff0
I 08 02500114
I 09 00022000
I 0a 2a920007
W 01 00000005
W 02 00000008
W 03 0000000d
W 04 00000008
W 05 00000080
W 06 00000088
W 07 00000008
W 08 fffffff0
W 09 fffffffc
W 0a 00000003
T load_use
I 0b 42c00004
I 0c 03161000
I 0d 43400005
I 0e 2b9a0001
D 04 00001000
D 05 000000ff
W 0b 00001000
W 0c 00001005
W 0d 000000ff
W 0e 00000100
T store
I 0f 2bc00020
I 10 3bde0001
I 11 2c1e0011
I 12 3c140002
I 13 44400005
W 0f 00000020
S 21 00000020
W 10 00000031
S 05 00000031
W 11 00000031
T branch
I 14 2c800001
I 15 14800003
I 16 2cc00099
I 17 2d000098
I 19 11040002
I 1a 2da40040
I 1b 2dec0002
W 12 00000001
W 16 00000041
W 17 00000043
T jump
I 1c 0800001f
I 1d 2e000055
I 1f 2e820010
I 20 08000020
W 1a 00000015

// ==== tb.f ====
rtl/cpu_pkg.sv
rtl/fwd_if.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/cpu_top.sv
bench/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CPU testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_cpu -f tb.f -o sim_cpu
./obj_dir/sim_cpu 2>&1 | tee sim.log

if grep -q "Checks failed" sim.log; then
   echo "simulation reported failures"
   exit 1
fi
echo "simulation finished without failures"

// ==== bench/tb_cpu.sv ====
// ======================================================================
// Testbench for the five-stage CPU
// Same-cycle instruction and data memory models, vector file loading,
// write-back and store checking with per-test reporting
// ======================================================================
module tb_cpu;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int mem_words  = 256;
   localparam int max_cycles = 200;   // Per test

   logic        clk;
   logic        clr;
   logic [31:0] imem_addr, imem_data;
   logic [31:0] dmem_addr, dmem_wdata, dmem_rdata;
   logic        dmem_wren;
   logic        wb_en;
   logic [4:0]  wb_reg;
   logic [31:0] wb_data;

   logic [31:0] imem [mem_words];
   logic [31:0] dmem [mem_words];

   string       test_names [$];
   int          left [$];          // Expectations still open
   int          errs [$];
   logic [31:0] w_reg [$];
   logic [31:0] w_val [$];
   logic [31:0] s_addr [$];
   logic [31:0] s_val [$];
   int          w_test [$];
   int          s_test [$];
   int          w_ptr, s_ptr;
   int          errors, passed, failed;
   bit          in_reset;

   cpu_top #(.reset_pc(32'h0)) cpu_top_i (
      .clk        (clk),
      .clr        (clr),
      .imem_addr  (imem_addr),
      .imem_data  (imem_data),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_wren  (dmem_wren),
      .dmem_rdata (dmem_rdata),
      .wb_en      (wb_en),
      .wb_reg     (wb_reg),
      .wb_data    (wb_data)
   );

   // Both memories answer in the same cycle
   assign imem_data  = imem[imem_addr[7:0]];
   assign dmem_rdata = dmem[dmem_addr[7:0]];

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic check_value(input int t, input string name,
                              input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
         errs[t]++;
      end
   endtask

   task automatic close_test(input int t);
      if (errs[t] == 0) begin
         $display("test %s passed", test_names[t]);
         passed++;
      end else begin
         $display("test %s failed with %0d errors", test_names[t], errs[t]);
         failed++;
      end
   endtask

   task automatic consume(input int t);
      left[t]--;
      if (left[t] == 0) close_test(t);
   endtask

   task automatic add_test(input string name);
      test_names.push_back(name);
      left.push_back(0);
      errs.push_back(0);
   endtask

   task automatic load_vectors;
      int          fd;
      int          t;
      string       line, name;
      logic [31:0] a, b;
      fd = $fopen("bench/cpu_vectors.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file bench/cpu_vectors.txt");
         errors++;
         return;
      end
      while ($fgets(line, fd) != 0) begin
         t = test_names.size() - 1;
         if (line.len() < 3 || line.getc(0) == "#") continue;
         if (line.getc(0) == "T") begin
            if ($sscanf(line, "T %s", name) == 1) add_test(name);
            continue;
         end
         if ($sscanf(line.substr(2, line.len() - 1), "%h %h", a, b) != 2) begin
            $display("malformed vector line: %s", line);
            errors++;
            continue;
         end
         case (line.getc(0))
            "I": imem[a[7:0]] = b;
            "D": dmem[a[7:0]] = b;
            "W": begin
               w_reg.push_back(a);
               w_val.push_back(b);
               w_test.push_back(t);
               left[t]++;
            end
            "S": begin
               s_addr.push_back(a);
               s_val.push_back(b);
               s_test.push_back(t);
               left[t]++;
            end
            default: begin
               $display("unknown vector line: %s", line);
               errors++;
            end
         endcase
      end
      $fclose(fd);
   endtask

   task automatic check_write_back;
      int t;
      if (w_ptr >= w_reg.size()) begin
         $display("write-back to r%0d at %0d ns was not expected", wb_reg, $time);
         errors++;
         return;
      end
      t = w_test[w_ptr];
      check_value(t, "wb_reg", 32'(wb_reg), w_reg[w_ptr]);
      check_value(t, "wb_data", wb_data, w_val[w_ptr]);
      w_ptr++;
      consume(t);
   endtask

   task automatic check_store;
      int t;
      if (dmem_addr < mem_words) dmem[dmem_addr[7:0]] = dmem_wdata;
      else begin
         $display("store at %0d ns goes outside the data memory", $time);
         errors++;
      end
      if (s_ptr >= s_addr.size()) begin
         $display("store to %h at %0d ns was not expected", dmem_addr, $time);
         errors++;
         return;
      end
      t = s_test[s_ptr];
      check_value(t, "dmem_addr", dmem_addr, s_addr[s_ptr]);
      check_value(t, "dmem_wdata", dmem_wdata, s_val[s_ptr]);
      s_ptr++;
      consume(t);
   endtask

   // Sampled mid-cycle when DUT outputs have settled
   always @(negedge clk) begin
      if (in_reset) begin
         check_value(0, "wb_en", 32'(wb_en), 32'h0);
         check_value(0, "dmem_wren", 32'(dmem_wren), 32'h0);
      end else begin
         if (wb_en) check_write_back();
         if (dmem_wren) check_store();
      end
   end

   task automatic wait_for_test(input int t, output bit ok);
      int n;
      n = 0;
      while (left[t] > 0 && n < max_cycles) begin
         @(posedge clk);
         n++;
      end
      ok = (left[t] == 0);
      if (!ok) begin
         $display("timed out waiting for %s", test_names[t]);
         failed++;
      end
   endtask

   initial begin
      bit ok;
      clr      = 1'b1;
      in_reset = 1'b1;
      w_ptr    = 0;
      s_ptr    = 0;
      errors   = 0;
      passed   = 0;
      failed   = 0;
      for (int i = 0; i < mem_words; i++) begin
         imem[i] = 32'h0;                 // nop
         dmem[i] = 32'hd000_0000 + i;
      end
      add_test("reset");                  // Entry 0 holds the reset checks
      load_vectors();
      repeat (16) @(posedge clk);
      #1;
      clr      = 1'b0;
      in_reset = 1'b0;
      close_test(0);
      for (int t = 1; t < test_names.size(); t++) begin
         wait_for_test(t, ok);
         if (!ok) break;
      end
      $display("%0d tests passed, %0d tests failed", passed, failed);
      if (errors == 0 && failed == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// ==== rtl/cpu_top.sv ====
// ======================================================================
// CPU top level
// Five pipeline stages with external instruction and data memories
// ======================================================================
module cpu_top #(
   parameter cpu_pkg::word_t reset_pc = '0
) (
   input  logic              clk,
   input  logic              clr,
   output cpu_pkg::word_t    imem_addr,
   input  cpu_pkg::word_t    imem_data,
   output cpu_pkg::word_t    dmem_addr,
   output cpu_pkg::word_t    dmem_wdata,
   output logic              dmem_wren,
   input  cpu_pkg::word_t    dmem_rdata,
   output logic              wb_en,
   output cpu_pkg::reg_idx_t wb_reg,
   output cpu_pkg::word_t    wb_data
);
   import cpu_pkg::*;

   word_t fd_pc, fd_instr;
   logic  stall, jump_taken, br_taken;
   word_t jump_target, br_target;
   dx_t   dx;
   xm_t   xm;

   fwd_if fwd ();

   fetch_stage #(.reset_pc(reset_pc)) fetch_i (
      .clk         (clk),
      .clr         (clr),
      .stall       (stall),
      .jump_taken  (jump_taken),
      .br_taken    (br_taken),
      .jump_target (jump_target),
      .br_target   (br_target),
      .imem_addr   (imem_addr),
      .imem_data   (imem_data),
      .fd_pc       (fd_pc),
      .fd_instr    (fd_instr)
   );

   decode_stage decode_i (
      .clk         (clk),
      .clr         (clr),
      .fd_pc       (fd_pc),
      .fd_instr    (fd_instr),
      .br_taken    (br_taken),
      .fwd         (fwd.dec),
      .stall       (stall),
      .jump_taken  (jump_taken),
      .jump_target (jump_target),
      .dx          (dx)
   );

   execute_stage execute_i (
      .clk       (clk),
      .clr       (clr),
      .dx        (dx),
      .fwd       (fwd.exe),
      .br_taken  (br_taken),
      .br_target (br_target),
      .xm        (xm)
   );

   mem_wb_stage mem_wb_i (
      .clk        (clk),
      .clr        (clr),
      .xm         (xm),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_wren  (dmem_wren),
      .dmem_rdata (dmem_rdata),
      .fwd        (fwd.src),
      .wb_en      (wb_en),
      .wb_reg     (wb_reg),
      .wb_data    (wb_data)
   );

endmodule

// ==== rtl/mem_wb_stage.sv ====
// ======================================================================
// Memory and write-back stages
// Data memory drive, memory/write-back register, result select
// ======================================================================
module mem_wb_stage (
   input  logic              clk,
   input  logic              clr,
   input  cpu_pkg::xm_t      xm,
   output cpu_pkg::word_t    dmem_addr,
   output cpu_pkg::word_t    dmem_wdata,
   output logic              dmem_wren,
   input  cpu_pkg::word_t    dmem_rdata,
   fwd_if.src                fwd,
   output logic              wb_en,
   output cpu_pkg::reg_idx_t wb_reg,
   output cpu_pkg::word_t    wb_data
);
   import cpu_pkg::*;

   // Memory answers in the same cycle
   assign dmem_addr  = xm.alu;
   assign dmem_wdata = xm.store;
   assign dmem_wren  = xm.opcode == op_sw;

   // A lw here is held back by the decode stall
   assign fwd.xm_wen = xm.wen;
   assign fwd.xm_rd  = xm.rd;
   assign fwd.xm_val = xm.alu;

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         wb_en  <= 1'b0;
         wb_reg <= '0;
      end else begin
         wb_en  <= xm.wen;
         wb_reg <= xm.rd;
      end
   end

   always_ff @(posedge clk) begin
      wb_data <= (xm.opcode == op_lw) ? dmem_rdata : xm.alu;
   end

   assign fwd.mw_wen = wb_en;
   assign fwd.mw_rd  = wb_reg;
   assign fwd.mw_val = wb_data;

endmodule

// ==== rtl/execute_stage.sv ====
// ======================================================================
// Execute stage
// Operand forwarding, ALU, bne resolution and the execute/memory register
// ======================================================================
module execute_stage (
   input  logic           clk,
   input  logic           clr,
   input  cpu_pkg::dx_t   dx,
   fwd_if.exe             fwd,
   output logic           br_taken,
   output cpu_pkg::word_t br_target,
   output cpu_pkg::xm_t   xm
);
   import cpu_pkg::*;

   reg_idx_t   src_b;
   word_t      op_a, op_b;
   word_t      alu_in_b, alu_out;
   logic       use_imm;
   alu_fn_e    fn;
   logic [4:0] shamt;
   xm_t        xm_next;

   // Memory stage first, then write-back, else the value read in decode
   function automatic word_t pick(reg_idx_t src, word_t reg_val);
      if (src != '0 && fwd.xm_wen && fwd.xm_rd == src) return fwd.xm_val;
      if (src != '0 && fwd.mw_wen && fwd.mw_rd == src) return fwd.mw_val;
      return reg_val;
   endfunction

   assign src_b = (dx.opcode == op_bne || dx.opcode == op_sw) ? dx.rd : dx.rt;

   always_comb begin
      op_a = pick(dx.rs, dx.val_a);
      op_b = pick(src_b, dx.val_b);
   end

   assign use_imm  = dx.opcode inside {op_addi, op_lw, op_sw};
   assign alu_in_b = use_imm ? dx.imm : op_b;
   assign fn       = (dx.opcode == op_rtype) ? dx.alu_fn : fn_add;   // Address calc adds
   assign shamt    = dx.imm[11:7];

   always_comb begin
      case (fn)
         fn_add:  alu_out = op_a + alu_in_b;
         fn_sub:  alu_out = op_a - alu_in_b;
         fn_and:  alu_out = op_a & alu_in_b;
         fn_or:   alu_out = op_a | alu_in_b;
         fn_sll:  alu_out = op_a << shamt;
         fn_sra:  alu_out = $signed(op_a) >>> shamt;
         default: alu_out = op_a + alu_in_b;
      endcase
   end

   // bne compares rs against rd
   assign br_taken  = dx.opcode == op_bne && op_a != op_b;
   assign br_target = dx.pc + 32'd1 + dx.imm;

   always_comb begin
      xm_next.opcode = dx.opcode;
      xm_next.rd     = dx.rd;
      xm_next.wen    = dx.wen;
      xm_next.alu    = alu_out;
      xm_next.store  = op_b;   // Forwarded like any operand
   end

   always_ff @(posedge clk or posedge clr) begin
      if (clr) xm <= '0;
      else     xm <= xm_next;
   end

   // Only a bne redirects, and the slot behind it comes in as a bubble
   a_br_source: assert property (@(posedge clk) disable iff (clr)
      br_taken |-> (dx.opcode == op_bne) ##1 !dx.wen);

endmodule

// ==== rtl/decode_stage.sv ====
// ======================================================================
// Decode stage
// Field split, register reads, jump redirect, load-use stall
// and the decode/execute register
// ======================================================================
module decode_stage (
   input  logic           clk,
   input  logic           clr,
   input  cpu_pkg::word_t fd_pc,
   input  cpu_pkg::word_t fd_instr,
   input  logic           br_taken,
   fwd_if.dec             fwd,
   output logic           stall,
   output logic           jump_taken,
   output cpu_pkg::word_t jump_target,
   output cpu_pkg::dx_t   dx
);
   import cpu_pkg::*;

   opcode_e  fd_op;
   reg_idx_t fd_src_b;
   logic     fd_use_a, fd_use_b;
   word_t    instr;
   opcode_e  op;
   reg_idx_t rd, rs, rt, src_b;
   word_t    val_a, val_b;
   dx_t      dx_next;

   // Hazard check against a lw now in execute
   assign fd_op    = opcode_e'(fd_instr[31:27]);
   assign fd_src_b = (fd_op == op_bne || fd_op == op_sw) ? fd_instr[26:22] : fd_instr[16:12];
   assign fd_use_a = fd_op inside {op_rtype, op_addi, op_lw, op_sw, op_bne};
   assign fd_use_b = fd_op inside {op_rtype, op_sw, op_bne};
   assign stall = dx.opcode == op_lw && dx.wen &&
                  ((fd_use_a && fd_instr[21:17] == dx.rd) || (fd_use_b && fd_src_b == dx.rd));

   // Bubble on stall, squash under a taken branch
   assign instr = (stall || br_taken) ? nop_word : fd_instr;
   assign op    = opcode_e'(instr[31:27]);
   assign rd    = instr[26:22];
   assign rs    = instr[21:17];
   assign rt    = instr[16:12];
   assign src_b = (op == op_bne || op == op_sw) ? rd : rt;   // bne and sw read rd

   reg_file reg_file_i (
      .clk    (clk),
      .clr    (clr),
      .rd_a   (rs),
      .rd_b   (src_b),
      .val_a  (val_a),
      .val_b  (val_b),
      .wen    (fwd.mw_wen),
      .wr_reg (fwd.mw_rd),
      .wr_val (fwd.mw_val)
   );

   assign jump_taken  = op == op_j;
   assign jump_target = {{(xlen-tgt_w){instr[tgt_w-1]}}, instr[tgt_w-1:0]};

   always_comb begin
      dx_next.pc     = fd_pc;
      dx_next.opcode = op;
      dx_next.alu_fn = alu_fn_e'(instr[6:2]);
      dx_next.rd     = rd;
      dx_next.rs     = rs;
      dx_next.rt     = rt;
      dx_next.val_a  = val_a;
      dx_next.val_b  = val_b;
      dx_next.imm    = {{(xlen-imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]};
      dx_next.wen    = (op inside {op_rtype, op_addi, op_lw}) && rd != '0;
   end

   always_ff @(posedge clk or posedge clr) begin
      if (clr) dx <= '0;
      else     dx <= dx_next;
   end

   // A j never waits and the fetch behind it is dropped
   a_jump_flush: assert property (@(posedge clk) disable iff (clr)
      (fd_op == op_j && !br_taken) |-> !stall ##1 fd_instr == nop_word);

endmodule

// ==== rtl/reg_file.sv ====
// ======================================================================
// 32-entry register file, two read ports and one write port
// ======================================================================
module reg_file (
   input  logic               clk,
   input  logic               clr,
   input  cpu_pkg::reg_idx_t  rd_a,
   input  cpu_pkg::reg_idx_t  rd_b,
   output cpu_pkg::word_t     val_a,
   output cpu_pkg::word_t     val_b,
   input  logic               wen,
   input  cpu_pkg::reg_idx_t  wr_reg,
   input  cpu_pkg::word_t     wr_val
);
   import cpu_pkg::*;

   word_t regs [32];

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         for (int i = 0; i < 32; i++) regs[i] <= '0;
      end else if (wen && wr_reg != '0) begin
         regs[wr_reg] <= wr_val;
      end
   end

   // Same-cycle write shows through to decode
   assign val_a = (rd_a == '0) ? '0 : (wen && wr_reg == rd_a) ? wr_val : regs[rd_a];
   assign val_b = (rd_b == '0) ? '0 : (wen && wr_reg == rd_b) ? wr_val : regs[rd_b];

endmodule

// ==== rtl/fetch_stage.sv ====
// ======================================================================
// Fetch stage
// Program counter, next-pc select and the fetch/decode register
// ======================================================================
module fetch_stage #(
   parameter cpu_pkg::word_t reset_pc = '0
) (
   input  logic           clk,
   input  logic           clr,
   input  logic           stall,
   input  logic           jump_taken,
   input  logic           br_taken,
   input  cpu_pkg::word_t jump_target,
   input  cpu_pkg::word_t br_target,
   output cpu_pkg::word_t imem_addr,
   input  cpu_pkg::word_t imem_data,
   output cpu_pkg::word_t fd_pc,
   output cpu_pkg::word_t fd_instr
);
   import cpu_pkg::*;

   word_t pc;
   word_t pc_next;

   assign imem_addr = pc;

   // Branch beats jump, jump beats sequential
   assign pc_next = br_taken   ? br_target :
                    jump_taken ? jump_target : pc + 32'd1;

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         pc       <= reset_pc;
         fd_pc    <= '0;
         fd_instr <= nop_word;
      end else if (br_taken || jump_taken) begin
         pc       <= pc_next;
         fd_instr <= nop_word;   // Drop the wrong-path fetch
      end else if (!stall) begin
         pc       <= pc_next;
         fd_pc    <= pc;
         fd_instr <= imem_data;
      end
   end

   // Load-use stall freezes the front end
   a_pc_hold: assert property (@(posedge clk) disable iff (clr)
      stall |=> pc == $past(pc));

endmodule

// ==== rtl/fwd_if.sv ====
// ======================================================================
// Forwarding bus from the memory and write-back stages
// ======================================================================
interface fwd_if;
   import cpu_pkg::*;

   // Result sitting in the memory stage
   logic     xm_wen;
   reg_idx_t xm_rd;
   word_t    xm_val;

   // Value being written back this cycle
   logic     mw_wen;
   reg_idx_t mw_rd;
   word_t    mw_val;

   modport src (
      output xm_wen, xm_rd, xm_val,
      output mw_wen, mw_rd, mw_val
   );

   modport exe (
      input xm_wen, xm_rd, xm_val,
      input mw_wen, mw_rd, mw_val
   );

   modport dec (input mw_wen, mw_rd, mw_val);

endinterface

// ==== rtl/cpu_pkg.sv ====
// ======================================================================
// Shared definitions for the five-stage CPU
// Field widths, opcode and ALU function enums, stage register structs
// ======================================================================
package cpu_pkg;

   localparam int xlen  = 32;
   localparam int op_w  = 5;
   localparam int fn_w  = 5;
   localparam int reg_w = 5;
   localparam int imm_w = 17;   // Signed immediate in bits 16:0
   localparam int tgt_w = 27;   // Signed jump target in bits 26:0

   typedef logic [xlen-1:0]  word_t;
   typedef logic [reg_w-1:0] reg_idx_t;

   typedef enum logic [op_w-1:0] {
      op_rtype = 5'b00000,
      op_j     = 5'b00001,
      op_bne   = 5'b00010,
      op_addi  = 5'b00101,
      op_sw    = 5'b00111,
      op_lw    = 5'b01000
   } opcode_e;

   typedef enum logic [fn_w-1:0] {
      fn_add = 5'b00000,
      fn_sub = 5'b00001,
      fn_and = 5'b00010,
      fn_or  = 5'b00011,
      fn_sll = 5'b00100,
      fn_sra = 5'b00101
   } alu_fn_e;

   // add r0, r0, r0
   localparam word_t nop_word = '0;

   typedef struct packed {
      word_t    pc;       // Address of this instruction
      opcode_e  opcode;
      alu_fn_e  alu_fn;
      reg_idx_t rd;
      reg_idx_t rs;
      reg_idx_t rt;
      word_t    val_a;    // Always read through rs
      word_t    val_b;    // Read through rd for bne and sw
      word_t    imm;      // Sign extended
      logic     wen;
   } dx_t;

   typedef struct packed {
      opcode_e  opcode;
      reg_idx_t rd;
      logic     wen;
      word_t    alu;
      word_t    store;
   } xm_t;

endpackage
